// ==== src/shader_pkg.sv ====
package shader_pkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////

	localparam int SHADER_LANES = 4;
	localparam int NUM_GROUPS   = 4;
	localparam int NUM_VGPRS    = 8;
	localparam int NUM_SGPRS    = 8;
	localparam int SFU_CREDITS  = 1;

	typedef logic [31:0]              word;
	typedef logic [1:0]               group_id;
	typedef logic [2:0]               reg_num;
	typedef logic [SHADER_LANES-1:0]  lane_mask;
	typedef logic [15:0]              pc_t;
	typedef logic signed [7:0]        pc_offset;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_MUL,
		OP_BRANCH,
		OP_SETMASK,
		OP_ISQRT
	} shader_op;

	typedef enum logic [1:0] {
		SET_SGPR,
		SET_MASK,
		SET_PC
	} setup_kind;

	////////////////////////////////////////
	// Pipe and port payloads
	////////////////////////////////////////

	typedef struct packed {
		logic                    valid;
		shader_op                op;
		group_id                 group;
		reg_num                  dest;
		logic                    scalar;
		logic                    writeback;
		word [SHADER_LANES-1:0]  a;
		word [SHADER_LANES-1:0]  b;
		pc_offset                offset;
	} dispatch_t;

	// A result always moves the pc, either by pc_add or by one when pc_inc is set.
	typedef struct packed {
		logic                    valid;
		group_id                 group;
		reg_num                  dest;
		logic                    scalar;
		logic                    writeback;
		word [SHADER_LANES-1:0]  lanes;
		lane_mask                mask;
		logic                    mask_update;
		pc_offset                pc_add;
		logic                    pc_inc;
		logic                    pc_update;
	} result_t;

	typedef struct packed {
		logic       valid;
		setup_kind  kind;
		group_id    group;
		reg_num     reg_id;
		word        value;
	} setup_t;

	typedef struct packed {
		logic     valid;
		group_id  group;
		pc_t      pc;
	} loop_t;

endpackage

// ==== src/shader_fpint.sv ====
`timescale 1ns/1ps

module shader_fpint
import shader_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  dispatch_t dispatch,
	output result_t   res
);

	dispatch_t s1;
	result_t   s2;
	result_t   next;
	logic      s1_valid;
	logic      s2_valid;

	always_comb begin
		next = '0;
		next.group = s1.group;
		next.dest = s1.dest;
		next.scalar = s1.scalar;
		next.writeback = s1.writeback;
		next.pc_inc = 1'b1;

		case (s1.op)
			OP_ADD:
				for (int i = 0; i < SHADER_LANES; i++)
					next.lanes[i] = s1.a[i] + s1.b[i];
			OP_SUB:
				for (int i = 0; i < SHADER_LANES; i++)
					next.lanes[i] = s1.a[i] - s1.b[i];
			OP_AND:
				for (int i = 0; i < SHADER_LANES; i++)
					next.lanes[i] = s1.a[i] & s1.b[i];
			OP_MUL:
				for (int i = 0; i < SHADER_LANES; i++)
					next.lanes[i] = s1.a[i] * s1.b[i];
			OP_BRANCH: begin
				// The branch condition is taken from lane 0 only.
				next.writeback = 1'b0;
				next.pc_update = 1'b1;
				if (s1.a[0] != '0) begin
					next.pc_inc = 1'b0;
					next.pc_add = s1.offset;
				end
			end
			OP_SETMASK: begin
				next.writeback = 1'b0;
				next.mask_update = 1'b1;
				for (int i = 0; i < SHADER_LANES; i++)
					next.mask[i] = |s1.a[i];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= dispatch.valid & (dispatch.op != OP_ISQRT);
			s2_valid <= s1_valid;
		end

	always_ff @(posedge clk) begin
		if (dispatch.valid)
			s1 <= dispatch;
		if (s1_valid)
			s2 <= next;
	end

	always_comb begin
		res = s2;
		res.valid = s2_valid;
	end

endmodule

// ==== src/shader_sfu.sv ====
`timescale 1ns/1ps

module shader_sfu
import shader_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  dispatch_t dispatch,
	output result_t   res,
	input  logic      ready,
	output logic      credit
);

	typedef enum logic [1:0] {IDLE, ITER, HOLD} sfu_state;

	sfu_state                       state;
	dispatch_t                      held;
	logic [3:0]                     count;
	logic                           start;
	logic [SHADER_LANES-1:0][31:0]  rad;
	logic [SHADER_LANES-1:0][17:0]  rem;
	logic [SHADER_LANES-1:0][15:0]  root;
	logic [SHADER_LANES-1:0][19:0]  shifted;
	logic [SHADER_LANES-1:0][19:0]  diff;

	assign start = dispatch.valid & (dispatch.op == OP_ISQRT) & (state == IDLE);
	assign credit = (state == HOLD) & ready;

	// One result bit per cycle: bring down two radicand bits and try root*4+1.
	always_comb
		for (int i = 0; i < SHADER_LANES; i++) begin
			shifted[i] = {rem[i], rad[i][31:30]};
			diff[i] = shifted[i] - {2'b00, root[i], 2'b01};
		end

	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n)
			state <= IDLE;
		else
			case (state)
				IDLE: if (start) state <= ITER;
				ITER: if (count == 4'd15) state <= HOLD;
				HOLD: if (ready) state <= IDLE;
				default: state <= IDLE;
			endcase

	always_ff @(posedge clk)
		if (start) begin
			held <= dispatch;
			count <= '0;
			rad <= dispatch.a;
			rem <= '0;
			root <= '0;
		end else if (state == ITER) begin
			count <= count + 4'd1;
			for (int i = 0; i < SHADER_LANES; i++) begin
				rad[i] <= rad[i] << 2;
				if (~diff[i][19]) begin
					rem[i] <= diff[i][17:0];
					root[i] <= {root[i][14:0], 1'b1};
				end else begin
					rem[i] <= shifted[i][17:0];
					root[i] <= {root[i][14:0], 1'b0};
				end
			end
		end

	always_comb begin
		res = '0;
		res.valid = state == HOLD;
		res.group = held.group;
		res.dest = held.dest;
		res.scalar = held.scalar;
		res.writeback = held.writeback;
		res.pc_inc = 1'b1;
		for (int i = 0; i < SHADER_LANES; i++)
			res.lanes[i] = {16'd0, root[i]};
	end

endmodule

// ==== src/shader_wb_arbiter.sv ====
`timescale 1ns/1ps

module shader_wb_arbiter
import shader_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  result_t alu,
	input  result_t sfu,
	output logic    sfu_ready,
	output result_t out
);

	result_t out_q;
	logic    out_valid;

	// The ALU cannot stall, so it always takes the slot.
	assign sfu_ready = ~alu.valid;

	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= alu.valid | sfu.valid;

	always_ff @(posedge clk)
		if (alu.valid)
			out_q <= alu;
		else if (sfu.valid)
			out_q <= sfu;

	always_comb begin
		out = out_q;
		out.valid = out_valid;
	end

endmodule

// ==== src/shader_writeback.sv ====
`timescale 1ns/1ps

module shader_writeback
import shader_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,

	input  result_t                 wb,

	input  setup_t                  setup,
	output logic                    setup_done,

	output loop_t                   loop,

	input  pc_t                     cur_pc,
	input  lane_mask                cur_mask,

	output logic                    vgpr_we,
	output logic                    sgpr_we,
	output logic                    pc_we,
	output logic                    mask_we,
	output group_id                 wr_group,
	output reg_num                  wr_reg,
	output word [SHADER_LANES-1:0]  wr_lanes,
	output lane_mask                wr_lane_mask,
	output pc_t                     wr_pc,
	output lane_mask                wr_mask
);

	logic     setup_apply;
	logic     setup_seen;
	logic     loop_valid;
	group_id  loop_group;
	pc_t      loop_pc;
	pc_t      pc_step;

	// Setup only gets the register file when no result is being written.
	assign setup_apply = setup.valid & ~setup_seen & ~wb.valid;
	assign pc_step = wb.pc_inc ? 16'd1 : {{8{wb.pc_add[7]}}, wb.pc_add};

	always_comb begin
		vgpr_we = 1'b0;
		sgpr_we = 1'b0;
		pc_we = 1'b0;
		mask_we = 1'b0;
		wr_group = setup.group;
		wr_reg = setup.reg_id;
		wr_lanes = wb.lanes;
		wr_lane_mask = cur_mask;
		wr_pc = cur_pc + pc_step;
		wr_mask = wb.mask;

		if (wb.valid) begin
			wr_group = wb.group;
			wr_reg = wb.dest;
			vgpr_we = wb.writeback & ~wb.scalar;
			sgpr_we = wb.writeback & wb.scalar;
			mask_we = wb.mask_update;
			pc_we = wb.pc_update | wb.pc_inc;
		end else if (setup_apply) begin
			wr_lanes[0] = setup.value;
			wr_pc = setup.value[15:0];
			wr_mask = setup.value[SHADER_LANES-1:0];
			case (setup.kind)
				SET_SGPR: sgpr_we = 1'b1;
				SET_MASK: mask_we = 1'b1;
				SET_PC:   pc_we = 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n) begin
			loop_valid <= 1'b0;
			setup_done <= 1'b0;
			setup_seen <= 1'b0;
		end else begin
			loop_valid <= wb.valid | (setup_apply & (setup.kind == SET_PC));
			setup_done <= setup_apply;
			// A held request is applied once and rearms when the host drops it.
			if (setup_apply)
				setup_seen <= 1'b1;
			else if (~setup.valid)
				setup_seen <= 1'b0;
		end

	always_ff @(posedge clk) begin
		loop_group <= wr_group;
		loop_pc <= wr_pc;
	end

	always_comb begin
		loop.valid = loop_valid;
		loop.group = loop_group;
		loop.pc = loop_pc;
	end

endmodule

// ==== src/shader_regfile.sv ====
`timescale 1ns/1ps

module shader_regfile
import shader_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    vgpr_we,
	input  logic                    sgpr_we,
	input  logic                    pc_we,
	input  logic                    mask_we,
	input  group_id                 wr_group,
	input  reg_num                  wr_reg,
	input  word [SHADER_LANES-1:0]  wr_lanes,
	input  lane_mask                wr_lane_mask,
	input  pc_t                     wr_pc,
	input  lane_mask                wr_mask,

	output pc_t                     cur_pc,
	output lane_mask                cur_mask,

	input  group_id                 rd_group,
	input  reg_num                  rd_reg,
	output word [SHADER_LANES-1:0]  rd_vgpr_data,
	output word                     rd_sgpr_data
);

	word [SHADER_LANES-1:0]  vgprs[NUM_GROUPS][NUM_VGPRS];
	word                     sgprs[NUM_GROUPS][NUM_SGPRS];
	pc_t                     pcs[NUM_GROUPS];
	lane_mask                masks[NUM_GROUPS];

	assign cur_pc = pcs[wr_group];
	assign cur_mask = masks[wr_group];
	assign rd_vgpr_data = vgprs[rd_group][rd_reg];
	assign rd_sgpr_data = sgprs[rd_group][rd_reg];

	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n) begin
			for (int g = 0; g < NUM_GROUPS; g++) begin
				pcs[g] <= '0;
				masks[g] <= '1;
				for (int r = 0; r < NUM_VGPRS; r++)
					vgprs[g][r] <= '0;
				for (int r = 0; r < NUM_SGPRS; r++)
					sgprs[g][r] <= '0;
			end
		end else begin
			if (vgpr_we)
				for (int l = 0; l < SHADER_LANES; l++)
					if (wr_lane_mask[l])
						vgprs[wr_group][wr_reg][l] <= wr_lanes[l];
			if (sgpr_we)
				sgprs[wr_group][wr_reg] <= wr_lanes[0];
			if (pc_we)
				pcs[wr_group] <= wr_pc;
			if (mask_we)
				masks[wr_group] <= wr_mask;
		end

endmodule

// ==== src/shader_back.sv ====
`timescale 1ns/1ps

module shader_back
import shader_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  dispatch_t               dispatch,
	output logic                    sfu_credit,
	input  setup_t                  setup,
	output logic                    setup_done,
	output loop_t                   loop,
	input  group_id                 rd_group,
	input  reg_num                  rd_reg,
	output word [SHADER_LANES-1:0]  rd_vgpr_data,
	output word                     rd_sgpr_data
);

	result_t                 alu_res;
	result_t                 sfu_res;
	result_t                 wb_res;
	logic                    sfu_ready;
	logic                    vgpr_we;
	logic                    sgpr_we;
	logic                    pc_we;
	logic                    mask_we;
	group_id                 wr_group;
	reg_num                  wr_reg;
	word [SHADER_LANES-1:0]  wr_lanes;
	lane_mask                wr_lane_mask;
	pc_t                     wr_pc;
	lane_mask                wr_mask;
	pc_t                     cur_pc;
	lane_mask                cur_mask;

	////////////////////////////////////////
	// Execution pipes
	////////////////////////////////////////

	shader_fpint fpint
	(
		.clk,
		.rst_n,
		.dispatch,
		.res(alu_res)
	);

	shader_sfu sfu
	(
		.clk,
		.rst_n,
		.dispatch,
		.res(sfu_res),
		.ready(sfu_ready),
		.credit(sfu_credit)
	);

	shader_wb_arbiter arbiter
	(
		.clk,
		.rst_n,
		.alu(alu_res),
		.sfu(sfu_res),
		.sfu_ready,
		.out(wb_res)
	);

	////////////////////////////////////////
	// Writeback and register file
	////////////////////////////////////////

	shader_writeback writeback
	(
		.clk,
		.rst_n,
		.wb(wb_res),
		.setup,
		.setup_done,
		.loop,
		.cur_pc,
		.cur_mask,
		.vgpr_we,
		.sgpr_we,
		.pc_we,
		.mask_we,
		.wr_group,
		.wr_reg,
		.wr_lanes,
		.wr_lane_mask,
		.wr_pc,
		.wr_mask
	);

	shader_regfile regfile
	(
		.clk,
		.rst_n,
		.vgpr_we,
		.sgpr_we,
		.pc_we,
		.mask_we,
		.wr_group,
		.wr_reg,
		.wr_lanes,
		.wr_lane_mask,
		.wr_pc,
		.wr_mask,
		.cur_pc,
		.cur_mask,
		.rd_group,
		.rd_reg,
		.rd_vgpr_data,
		.rd_sgpr_data
	);

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset is released on a falling edge after four rising edges.
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== test/shader_back_checker.sv ====
`timescale 1ns/1ps

module shader_back_checker
import shader_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  loop_t                   loop,
	input  logic                    setup_done,
	input  logic                    sfu_credit,
	input  word [SHADER_LANES-1:0]  rd_vgpr_data,
	input  word                     rd_sgpr_data
);

	loop_t exp_q[$];
	int    pending[NUM_GROUPS];
	int    errors = 0;
	int    loops_seen = 0;
	int    reads_seen = 0;
	int    setups_expected = 0;
	int    setups_seen = 0;
	int    credits_expected = 0;
	int    credits_seen = 0;
	int    found;

	initial
		for (int g = 0; g < NUM_GROUPS; g++)
			pending[g] = 0;

	task automatic expect_loop(input int g, input int pc);
		loop_t e;
		e = '0;
		e.group = g;
		e.pc = pc;
		exp_q.push_back(e);
		pending[g]++;
	endtask

	task automatic expect_setup();
		setups_expected++;
	endtask

	task automatic expect_credit();
		credits_expected++;
	endtask

	task automatic check_vgpr(input word exp[SHADER_LANES]);
		@(posedge clk);
		reads_seen++;
		for (int l = 0; l < SHADER_LANES; l++)
			if (rd_vgpr_data[l] !== exp[l]) begin
				$display("ERROR %0t: vgpr lane %0d read %h, expected %h",
					$time, l, rd_vgpr_data[l], exp[l]);
				errors++;
			end
	endtask

	task automatic check_sgpr(input word exp);
		@(posedge clk);
		reads_seen++;
		if (rd_sgpr_data !== exp) begin
			$display("ERROR %0t: sgpr read %h, expected %h", $time, rd_sgpr_data, exp);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// Loop events, in order per group
	////////////////////////////////////////

	always @(posedge clk)
		if (rst_n && loop.valid) begin
			loops_seen++;
			found = -1;
			for (int i = 0; i < exp_q.size(); i++)
				if (found < 0 && exp_q[i].group == loop.group)
					found = i;
			if (found < 0) begin
				$display("ERROR %0t: unexpected loop event for group %0d", $time, loop.group);
				errors++;
			end else begin
				if (exp_q[found].pc !== loop.pc) begin
					$display("ERROR %0t: group %0d loop pc %h, expected %h",
						$time, loop.group, loop.pc, exp_q[found].pc);
					errors++;
				end
				exp_q.delete(found);
				pending[loop.group]--;
			end
		end

	always @(posedge clk)
		if (rst_n && setup_done)
			setups_seen++;

	always @(posedge clk)
		if (rst_n && sfu_credit)
			credits_seen++;

	task automatic report();
		if (exp_q.size() != 0) begin
			$display("ERROR %0t: %0d loop events never arrived", $time, exp_q.size());
			errors++;
		end
		if (setups_seen != setups_expected) begin
			$display("ERROR %0t: %0d setup_done pulses, expected %0d",
				$time, setups_seen, setups_expected);
			errors++;
		end
		if (credits_seen != credits_expected) begin
			$display("ERROR %0t: %0d sfu_credit pulses, expected %0d",
				$time, credits_seen, credits_expected);
			errors++;
		end
		$display("Checked %0d loop events, %0d reads, %0d setups, %0d credits: %0d errors",
			loops_seen, reads_seen, setups_seen, credits_seen, errors);
	endtask

endmodule

// ==== test/shader_back_assert.sv ====
`timescale 1ns/1ps

module shader_back_assert
import shader_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input dispatch_t dispatch,
	input logic      sfu_credit,
	input result_t   sfu_res,
	input logic      sfu_ready,
	input setup_t    setup,
	input logic      setup_done,
	input loop_t     loop
);

	logic isqrt_issue;
	int   outstanding;

	assign isqrt_issue = dispatch.valid && (dispatch.op == OP_ISQRT);

	// Square roots handed to the SFU whose credit has not come back yet.
	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(isqrt_issue) - int'(sfu_credit);

	// A credit only comes back for a square root that is still in the SFU.
	credit_granted: assert property (@(posedge clk) disable iff (!rst_n)
		sfu_credit |-> (outstanding > 0))
		else $error("sfu_credit without an outstanding SFU result");

	sfu_held: assert property (@(posedge clk) disable iff (!rst_n)
		(sfu_res.valid && !sfu_ready) |=> (sfu_res.valid && $stable(sfu_res)))
		else $error("SFU result changed before it was granted");

	reset_quiet: assert property (@(posedge clk) !rst_n |-> (!loop.valid && !setup_done))
		else $error("loop or setup_done active in reset");

	setup_held: assert property (@(posedge clk) disable iff (!rst_n)
		(setup.valid && !setup_done) |=> (setup_done || $stable(setup)))
		else $error("setup changed before setup_done");

endmodule

bind shader_back shader_back_assert sva (
	.clk,
	.rst_n,
	.dispatch,
	.sfu_credit,
	.sfu_res,
	.sfu_ready,
	.setup,
	.setup_done,
	.loop
);

// ==== test/shader_back_tb.sv ====
`timescale 1ns/1ps

module shader_back_tb
import shader_pkg::*;
;

	logic                    clk;
	logic                    rst_n;
	dispatch_t               dispatch;
	logic                    sfu_credit;
	setup_t                  setup;
	logic                    setup_done;
	loop_t                   loop;
	group_id                 rd_group;
	reg_num                  rd_reg;
	word [SHADER_LANES-1:0]  rd_vgpr_data;
	word                     rd_sgpr_data;

	int   seed = 32'h4588;
	int   cycles = 0;
	int   limit = 0;
	logic setup_busy = 1'b0;

	tb_clock clock_gen (.clk, .rst_n);

	shader_back UUT (.*);

	shader_back_checker chk (.*);

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout: DUT stopped producing loop events");
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic finish_setup();
		if (setup_busy) begin
			do @(negedge clk); while (!setup_done);
			setup = '0;
			setup_busy = 1'b0;
			@(negedge clk);
		end
	endtask

	task automatic quiesce();
		finish_setup();
		for (int g = 0; g < NUM_GROUPS; g++)
			while (chk.pending[g] != 0)
				@(negedge clk);
	endtask

	////////////////////////////////////////
	// Stimulus from the stim file
	////////////////////////////////////////

	initial begin
		int    fd;
		int    r;
		int    n;
		int    f[14];
		byte   code;
		string line;
		word   lanes[SHADER_LANES];

		dispatch = '0;
		setup = '0;
		rd_group = '0;
		rd_reg = '0;

		fd = $fopen("test/shader_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open test/shader_stim.txt");
			$display("Simulation failed");
			$finish;
		end else begin
			n = 0;
			while ($fscanf(fd, " %c", code) == 1) begin
				if (code != "#")
					n++;
				r = $fgets(line, fd);
			end
			$fclose(fd);
			limit = n * 40;

			fd = $fopen("test/shader_stim.txt", "r");
			@(posedge rst_n);
			@(negedge clk);

			while ($fscanf(fd, " %c", code) == 1) begin
				case (code)
					"D": begin
						for (int i = 0; i < 14; i++)
							r = $fscanf(fd, " %h", f[i]);
						finish_setup();
						if (f[0] == OP_ISQRT) begin
							while (SFU_CREDITS - chk.credits_expected + chk.credits_seen <= 0)
								@(negedge clk);
							chk.expect_credit();
						end
						while (chk.pending[f[1]] != 0)
							@(negedge clk);
						repeat ($unsigned($random(seed)) % 4) @(negedge clk);
						dispatch.valid = 1'b1;
						dispatch.op = shader_op'(f[0]);
						dispatch.group = f[1];
						dispatch.dest = f[2];
						dispatch.scalar = f[3];
						dispatch.writeback = f[4];
						for (int l = 0; l < SHADER_LANES; l++) begin
							dispatch.a[l] = f[5 + l];
							dispatch.b[l] = f[9 + l];
						end
						dispatch.offset = f[13];
						@(negedge clk);
						dispatch = '0;
					end
					"L": begin
						r = $fscanf(fd, " %h %h", f[0], f[1]);
						chk.expect_loop(f[0], f[1]);
					end
					"S": begin
						r = $fscanf(fd, " %h %h %h %h", f[0], f[1], f[2], f[3]);
						finish_setup();
						// A setup follows the group's earlier instructions.
						while (chk.pending[f[1]] != 0)
							@(negedge clk);
						setup.valid = 1'b1;
						setup.kind = setup_kind'(f[0]);
						setup.group = f[1];
						setup.reg_id = f[2];
						setup.value = f[3];
						setup_busy = 1'b1;
						chk.expect_setup();
					end
					"V": begin
						r = $fscanf(fd, " %h %h", f[0], f[1]);
						for (int l = 0; l < SHADER_LANES; l++)
							r = $fscanf(fd, " %h", lanes[l]);
						quiesce();
						rd_group = f[0];
						rd_reg = f[1];
						chk.check_vgpr(lanes);
						@(negedge clk);
					end
					"R": begin
						r = $fscanf(fd, " %h %h %h", f[0], f[1], f[2]);
						quiesce();
						rd_group = f[0];
						rd_reg = f[1];
						chk.check_sgpr(f[2]);
						@(negedge clk);
					end
					default: r = $fgets(line, fd);
				endcase
			end
			$fclose(fd);

			quiesce();
			repeat (4) @(negedge clk);
			chk.report();
			if (chk.errors == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

// ==== test/shader_stim.txt ====
# D op group dest scalar writeback a0 a1 a2 a3 b0 b1 b2 b3 offset | L group pc
# S kind group reg value | V group reg lane0..lane3 | R group reg value  (all hex)
D 0 0 1 0 1 1 2 3 4 a 14 1e 28 0
L 0 1
S 1 0 0 5
D 1 0 2 0 1 64 64 64 64 1 2 3 4 0
L 0 2
D 3 0 3 0 1 3 3 3 3 5 6 7 8 0
L 0 3
V 0 1 b 16 21 2c
V 0 2 63 0 61 0
V 0 3 f 0 15 0
D 2 2 4 1 1 ff0 0 0 0 ff 0 0 0 0
L 2 1
R 2 4 f0
# Square roots on group 1 while ALU traffic runs on the other groups.
D 6 1 5 0 1 0 f 10 ffffffff 0 0 0 0 0
L 1 1
D 0 3 0 0 1 1 1 1 1 2 2 2 2 0
L 3 1
D 3 2 1 0 1 7 7 7 7 6 6 6 6 0
L 2 2
D 0 3 1 0 1 5 5 5 5 5 5 5 5 0
L 3 2
D 1 2 2 0 1 9 9 9 9 4 4 4 4 0
L 2 3
D 0 3 2 0 1 8 8 8 8 8 8 8 8 0
L 3 3
D 2 0 4 0 1 ff ff ff ff f0 f0 f0 f0 0
L 0 4
D 6 1 6 0 1 64 63 80000000 fffe0001 0 0 0 0 0
L 1 2
D 0 2 3 0 1 1 2 3 4 1 1 1 1 0
L 2 4
D 0 3 3 0 1 2 2 2 2 3 3 3 3 0
L 3 4
V 1 5 0 3 4 ffff
V 1 6 a 9 b504 ffff
V 2 1 2a 2a 2a 2a
V 2 2 5 5 5 5
V 2 3 2 3 4 5
V 3 2 10 10 10 10
V 3 3 5 5 5 5
V 0 4 f0 0 f0 0
# Branches and mask changes.
D 4 0 0 0 0 1 0 0 0 0 0 0 0 5
L 0 9
D 4 0 0 0 0 0 0 0 0 0 0 0 0 5
L 0 a
D 4 0 0 0 0 1 0 0 0 0 0 0 0 fe
L 0 8
D 5 3 0 0 0 1 0 5 0 0 0 0 0 0
L 3 5
D 0 3 0 0 1 10 10 10 10 1 1 1 1 0
L 3 6
V 3 0 11 3 11 3
# Setup writes.
S 0 2 7 deadbeef
R 2 7 deadbeef
S 2 1 0 40
L 1 40
D 0 1 3 1 1 5 0 0 0 6 0 0 0 0
L 1 41
R 1 3 b
S 1 3 0 3
D 0 3 1 0 1 1 1 1 1 1 1 1 1 0
L 3 7
V 3 1 2 2 a a

// ==== vlog.f ====
src/shader_pkg.sv
src/shader_fpint.sv
src/shader_sfu.sv
src/shader_wb_arbiter.sv
src/shader_writeback.sv
src/shader_regfile.sv
src/shader_back.sv
test/tb_clock.sv
test/shader_back_checker.sv
test/shader_back_assert.sv
test/shader_back_tb.sv

// ==== Bender.yml ====
package:
  name: shader_back

sources:
  - files:
      - src/shader_pkg.sv
      - src/shader_fpint.sv
      - src/shader_sfu.sv
      - src/shader_wb_arbiter.sv
      - src/shader_writeback.sv
      - src/shader_regfile.sv
      - src/shader_back.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/shader_back_checker.sv
      - test/shader_back_assert.sv
      - test/shader_back_tb.sv
